//--- logic/conv_pkg.sv
package conv_pkg;

	localparam int KERNEL_SIZE = 3;
	localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE; // taps per slice
	localparam int FM_SIZE_MAX = 8;
	localparam int FM_SIZE_MIN = 4;
	localparam int FM_DEPTH_MAX = 2;
	localparam int PARA_KERNEL = 2; // kernels computed side by side
	localparam int OUT_SIZE_MAX = FM_SIZE_MAX - KERNEL_SIZE + 1;

	// ram depths, weights and results are per kernel
	localparam int FM_WORDS = FM_DEPTH_MAX * FM_SIZE_MAX * FM_SIZE_MAX;
	localparam int WEIGHT_WORDS = FM_DEPTH_MAX * KERNEL_TAPS;
	localparam int RESULT_WORDS = OUT_SIZE_MAX * OUT_SIZE_MAX;

	localparam int DATA_WIDTH = 8;
	localparam int ACC_WIDTH = 20; // holds 18 full scale products

	typedef logic signed [DATA_WIDTH-1:0] sample_t;
	typedef logic signed [ACC_WIDTH-1:0] acc_t;
	typedef logic [$clog2(FM_WORDS)-1:0] fm_addr_t;
	typedef logic [$clog2(WEIGHT_WORDS)-1:0] w_addr_t;
	typedef logic [$clog2(RESULT_WORDS)-1:0] res_addr_t;
	typedef logic [$clog2(FM_SIZE_MAX+1)-1:0] fm_size_t;
	typedef logic [11:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN
	} seq_state_t;

	// paddr is a word address, one ram word per location
	localparam apb_addr_t REG_CTRL = 12'h000;
	localparam apb_addr_t REG_CFG = 12'h004;
	localparam apb_addr_t FM_BASE = 12'h100;
	localparam apb_addr_t WEIGHT_BASE = 12'h200;
	localparam apb_addr_t WEIGHT_STRIDE = 12'h080; // kernel 1 at 0x280
	localparam apb_addr_t RESULT_BASE = 12'h400;
	localparam apb_addr_t RESULT_STRIDE = 12'h100; // kernel 1 at 0x500

endpackage

//--- logic/data_ram.sv
module data_ram #(
	parameter int DEPTH = 128,
	parameter int WIDTH = 8
) (
	input  logic clk,
	input  logic we_i,
	input  logic [$clog2(DEPTH)-1:0] waddr_i,
	input  logic [WIDTH-1:0] wdata_i,
	input  logic [$clog2(DEPTH)-1:0] raddr_i,
	output logic [WIDTH-1:0] rdata_o
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// one cycle read latency
	always_ff @(posedge clk) begin
		rdata_o <= mem[raddr_i];
	end

endmodule

//--- logic/apb_regs.sv
module apb_regs (
	input  logic clk,
	input  logic rst,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  conv_pkg::apb_addr_t paddr_i,
	input  conv_pkg::apb_data_t pwdata_i,
	output conv_pkg::apb_data_t prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input  logic run_done_i,
	input  conv_pkg::fm_addr_t seq_fm_addr_i,
	input  conv_pkg::w_addr_t seq_w_addr_i,
	input  conv_pkg::sample_t fm_rdata_i,
	input  conv_pkg::sample_t w0_rdata_i,
	input  conv_pkg::sample_t w1_rdata_i,
	input  conv_pkg::acc_t res0_rdata_i,
	input  conv_pkg::acc_t res1_rdata_i,
	output logic start_o,
	output conv_pkg::fm_size_t fm_size_o,
	output logic depth_o, // slice count minus one
	output logic fm_we_o,
	output logic w0_we_o,
	output logic w1_we_o,
	output conv_pkg::fm_addr_t wr_addr_o,
	output conv_pkg::sample_t wr_data_o,
	output conv_pkg::fm_addr_t fm_raddr_o,
	output conv_pkg::w_addr_t w_raddr_o,
	output conv_pkg::res_addr_t res_raddr_o
);

	logic access;
	logic busy;
	logic done;
	logic rd_wait;
	logic ctrl_hit;
	logic cfg_hit;
	logic fm_hit;
	logic w_hit;
	logic res_hit;
	logic ram_hit;
	logic w_sel;
	logic res_sel;
	logic err;
	logic hold;
	conv_pkg::apb_addr_t fm_off;
	conv_pkg::apb_addr_t w_off;
	conv_pkg::apb_addr_t res_off;
	conv_pkg::fm_size_t size_wr;
	conv_pkg::sample_t w_rdata;
	conv_pkg::acc_t res_rdata;

	assign access = psel_i && penable_i;

	assign fm_off = paddr_i - conv_pkg::FM_BASE;
	assign w_off = paddr_i - conv_pkg::WEIGHT_BASE;
	assign res_off = paddr_i - conv_pkg::RESULT_BASE;

	assign ctrl_hit = (paddr_i == conv_pkg::REG_CTRL);
	assign cfg_hit = (paddr_i == conv_pkg::REG_CFG);
	assign fm_hit = (paddr_i >= conv_pkg::FM_BASE) && (fm_off < conv_pkg::FM_WORDS);
	assign w_hit = (paddr_i >= conv_pkg::WEIGHT_BASE)
		&& (w_off < conv_pkg::PARA_KERNEL * conv_pkg::WEIGHT_STRIDE)
		&& ((w_off % conv_pkg::WEIGHT_STRIDE) < conv_pkg::WEIGHT_WORDS);
	assign res_hit = (paddr_i >= conv_pkg::RESULT_BASE)
		&& (res_off < conv_pkg::PARA_KERNEL * conv_pkg::RESULT_STRIDE)
		&& ((res_off % conv_pkg::RESULT_STRIDE) < conv_pkg::RESULT_WORDS);
	assign w_sel = (w_off >= conv_pkg::WEIGHT_STRIDE); // kernel 1 window
	assign res_sel = (res_off >= conv_pkg::RESULT_STRIDE);
	assign ram_hit = fm_hit || w_hit || res_hit;

	// results are written by the engine only
	assign err = !(ctrl_hit || cfg_hit || ram_hit) || (ram_hit && busy) || (res_hit && pwrite_i);

	// first access cycle of a ram read waits for the registered read data
	assign hold = access && !pwrite_i && ram_hit && !busy && !rd_wait;
	assign pready_o = !hold;
	assign pslverr_o = access && err;

	assign fm_we_o = access && pwrite_i && fm_hit && !busy;
	assign w0_we_o = access && pwrite_i && w_hit && !w_sel && !busy;
	assign w1_we_o = access && pwrite_i && w_hit && w_sel && !busy;
	assign wr_addr_o = fm_hit ? conv_pkg::fm_addr_t'(fm_off)
		: conv_pkg::fm_addr_t'(w_off % conv_pkg::WEIGHT_STRIDE);
	assign wr_data_o = pwdata_i[conv_pkg::DATA_WIDTH-1:0];

	// sequencer owns the read ports during a run
	assign fm_raddr_o = busy ? seq_fm_addr_i : conv_pkg::fm_addr_t'(fm_off);
	assign w_raddr_o = busy ? seq_w_addr_i : conv_pkg::w_addr_t'(w_off);
	assign res_raddr_o = conv_pkg::res_addr_t'(res_off);

	always_comb begin
		if (pwdata_i[3:0] < conv_pkg::FM_SIZE_MIN) begin
			size_wr = conv_pkg::fm_size_t'(conv_pkg::FM_SIZE_MIN);
		end else if (pwdata_i[3:0] > conv_pkg::FM_SIZE_MAX) begin
			size_wr = conv_pkg::fm_size_t'(conv_pkg::FM_SIZE_MAX);
		end else begin
			size_wr = pwdata_i[3:0];
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			start_o <= 1'b0;
			rd_wait <= 1'b0;
			fm_size_o <= conv_pkg::fm_size_t'(conv_pkg::FM_SIZE_MAX);
			depth_o <= 1'b0;
		end else begin
			start_o <= 1'b0;
			rd_wait <= hold;
			if (run_done_i) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (access && pwrite_i && !busy) begin // ctrl and cfg frozen during a run
				if (ctrl_hit && pwdata_i[0]) begin
					start_o <= 1'b1;
					busy <= 1'b1;
					done <= 1'b0;
				end
				if (cfg_hit) begin
					fm_size_o <= size_wr;
					depth_o <= pwdata_i[4];
				end
			end
		end
	end

	assign w_rdata = w_sel ? w1_rdata_i : w0_rdata_i;
	assign res_rdata = res_sel ? res1_rdata_i : res0_rdata_i;

	always_comb begin
		prdata_o = '0;
		if (!err) begin
			if (ctrl_hit) begin
				prdata_o = conv_pkg::apb_data_t'({done, busy});
			end else if (cfg_hit) begin
				prdata_o = conv_pkg::apb_data_t'({depth_o, fm_size_o});
			end else if (fm_hit) begin
				prdata_o = {{(32-conv_pkg::DATA_WIDTH){fm_rdata_i[conv_pkg::DATA_WIDTH-1]}},
					fm_rdata_i};
			end else if (w_hit) begin
				prdata_o = {{(32-conv_pkg::DATA_WIDTH){w_rdata[conv_pkg::DATA_WIDTH-1]}}, w_rdata};
			end else if (res_hit) begin
				prdata_o = {{(32-conv_pkg::ACC_WIDTH){res_rdata[conv_pkg::ACC_WIDTH-1]}}, res_rdata};
			end
		end
	end

endmodule

//--- logic/window_sequencer.sv
module window_sequencer (
	input  logic clk,
	input  logic rst,
	input  logic start_i,
	input  conv_pkg::fm_size_t fm_size_i,
	input  logic depth_i, // index of the last slice
	output conv_pkg::fm_addr_t fm_addr_o,
	output conv_pkg::w_addr_t w_addr_o,
	output logic tap_valid_o,
	output logic first_tap_o,
	output logic last_tap_o,
	output conv_pkg::res_addr_t res_addr_o,
	output logic run_done_o
);

	conv_pkg::seq_state_t state;
	logic [1:0] kx;
	logic [1:0] ky;
	logic slice;
	logic [2:0] ox;
	logic [2:0] oy;
	logic [2:0] out_last;
	logic [2:0] fm_x;
	logic [2:0] fm_y;
	logic drain_cnt;
	logic issue;
	logic kx_end;
	logic ky_end;
	logic slice_end;
	logic ox_end;
	logic oy_end;
	logic pos_first;
	logic pos_end;
	logic run_end;
	conv_pkg::res_addr_t pos_addr;

	assign out_last = 3'(fm_size_i - conv_pkg::KERNEL_SIZE); // last output index

	assign kx_end = (kx == 2'(conv_pkg::KERNEL_SIZE - 1));
	assign ky_end = (ky == 2'(conv_pkg::KERNEL_SIZE - 1));
	assign slice_end = (slice == depth_i);
	assign ox_end = (ox == out_last);
	assign oy_end = (oy == out_last);
	assign pos_first = (kx == 2'd0) && (ky == 2'd0) && !slice;
	assign pos_end = kx_end && ky_end && slice_end;
	assign run_end = pos_end && ox_end && oy_end;

	assign issue = (state == conv_pkg::RUN);

	// feature map layout is slice*64 + y*8 + x
	assign fm_x = ox + 3'(kx);
	assign fm_y = oy + 3'(ky);
	assign fm_addr_o = {slice, fm_y, fm_x};

	assign w_addr_o = conv_pkg::w_addr_t'(slice) * conv_pkg::w_addr_t'(conv_pkg::KERNEL_TAPS)
		+ conv_pkg::w_addr_t'(ky) * conv_pkg::w_addr_t'(conv_pkg::KERNEL_SIZE)
		+ conv_pkg::w_addr_t'(kx);

	assign pos_addr = conv_pkg::res_addr_t'(oy) * conv_pkg::res_addr_t'(conv_pkg::OUT_SIZE_MAX)
		+ conv_pkg::res_addr_t'(ox);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= conv_pkg::IDLE;
			kx <= '0;
			ky <= '0;
			slice <= 1'b0;
			ox <= '0;
			oy <= '0;
			drain_cnt <= 1'b0;
			tap_valid_o <= 1'b0;
			first_tap_o <= 1'b0;
			last_tap_o <= 1'b0;
			run_done_o <= 1'b0;
		end else begin
			// strobes trail the address by the ram latency
			tap_valid_o <= issue;
			first_tap_o <= issue && pos_first;
			last_tap_o <= issue && pos_end;
			run_done_o <= 1'b0;
			case (state)
				conv_pkg::IDLE: begin
					if (start_i) begin
						state <= conv_pkg::RUN;
						kx <= '0;
						ky <= '0;
						slice <= 1'b0;
						ox <= '0;
						oy <= '0;
					end
				end
				conv_pkg::RUN: begin
					if (!kx_end) begin
						kx <= kx + 2'd1;
					end else begin
						kx <= '0;
						if (!ky_end) begin
							ky <= ky + 2'd1;
						end else begin
							ky <= '0;
							if (!slice_end) begin
								slice <= 1'b1; // next input slice, same position
							end else begin
								slice <= 1'b0;
								if (!ox_end) begin
									ox <= ox + 3'd1;
								end else begin
									ox <= '0;
									oy <= oy_end ? 3'd0 : oy + 3'd1;
								end
							end
						end
					end
					if (run_end) begin
						state <= conv_pkg::DRAIN;
						drain_cnt <= 1'b0;
					end
				end
				conv_pkg::DRAIN: begin
					// wait for the last read and the result write
					drain_cnt <= 1'b1;
					if (drain_cnt) begin
						state <= conv_pkg::IDLE;
						run_done_o <= 1'b1;
					end
				end
				default: state <= conv_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		res_addr_o <= pos_addr;
	end

endmodule

//--- logic/mac_unit.sv
module mac_unit (
	input  logic clk,
	input  logic rst,
	input  logic tap_valid_i,
	input  logic first_tap_i,
	input  logic last_tap_i,
	input  conv_pkg::res_addr_t res_addr_i,
	input  conv_pkg::sample_t sample_i,
	input  conv_pkg::sample_t weight_i,
	output logic res_we_o,
	output conv_pkg::res_addr_t res_waddr_o,
	output conv_pkg::acc_t res_wdata_o
);

	logic signed [2*conv_pkg::DATA_WIDTH-1:0] prod;
	conv_pkg::acc_t acc;
	conv_pkg::acc_t acc_base;
	conv_pkg::acc_t acc_next;

	assign prod = sample_i * weight_i;
	assign acc_base = first_tap_i ? '0 : acc; // new window drops the old sum
	assign acc_next = acc_base + prod;

	always_ff @(posedge clk) begin
		if (tap_valid_i) begin
			acc <= acc_next;
		end
		if (tap_valid_i && last_tap_i) begin
			res_waddr_o <= res_addr_i;
			res_wdata_o <= acc_next; // includes the final product
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			res_we_o <= 1'b0;
		end else begin
			res_we_o <= tap_valid_i && last_tap_i;
		end
	end

endmodule

//--- logic/conv_layer_top.sv
module conv_layer_top (
	input  logic clk,
	input  logic rst,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  conv_pkg::apb_addr_t paddr_i,
	input  conv_pkg::apb_data_t pwdata_i,
	output conv_pkg::apb_data_t prdata_o,
	output logic pready_o,
	output logic pslverr_o
);

	logic start;
	conv_pkg::fm_size_t fm_size;
	logic depth;
	logic run_done;
	logic fm_we;
	logic w_we [conv_pkg::PARA_KERNEL];
	conv_pkg::fm_addr_t wr_addr;
	conv_pkg::sample_t wr_data;
	conv_pkg::fm_addr_t fm_raddr;
	conv_pkg::w_addr_t w_raddr;
	conv_pkg::res_addr_t res_raddr;
	conv_pkg::sample_t fm_rdata;
	conv_pkg::sample_t w_rdata [conv_pkg::PARA_KERNEL];
	conv_pkg::acc_t res_rdata [conv_pkg::PARA_KERNEL];
	conv_pkg::fm_addr_t seq_fm_addr;
	conv_pkg::w_addr_t seq_w_addr;
	conv_pkg::res_addr_t seq_res_addr;
	logic tap_valid;
	logic first_tap;
	logic last_tap;

	apb_regs i_apb_regs (
		.clk           (clk),
		.rst           (rst),
		.psel_i        (psel_i),
		.penable_i     (penable_i),
		.pwrite_i      (pwrite_i),
		.paddr_i       (paddr_i),
		.pwdata_i      (pwdata_i),
		.prdata_o      (prdata_o),
		.pready_o      (pready_o),
		.pslverr_o     (pslverr_o),
		.run_done_i    (run_done),
		.seq_fm_addr_i (seq_fm_addr),
		.seq_w_addr_i  (seq_w_addr),
		.fm_rdata_i    (fm_rdata),
		.w0_rdata_i    (w_rdata[0]),
		.w1_rdata_i    (w_rdata[1]),
		.res0_rdata_i  (res_rdata[0]),
		.res1_rdata_i  (res_rdata[1]),
		.start_o       (start),
		.fm_size_o     (fm_size),
		.depth_o       (depth),
		.fm_we_o       (fm_we),
		.w0_we_o       (w_we[0]),
		.w1_we_o       (w_we[1]),
		.wr_addr_o     (wr_addr),
		.wr_data_o     (wr_data),
		.fm_raddr_o    (fm_raddr),
		.w_raddr_o     (w_raddr),
		.res_raddr_o   (res_raddr)
	);

	window_sequencer i_window_sequencer (
		.clk         (clk),
		.rst         (rst),
		.start_i     (start),
		.fm_size_i   (fm_size),
		.depth_i     (depth),
		.fm_addr_o   (seq_fm_addr),
		.w_addr_o    (seq_w_addr),
		.tap_valid_o (tap_valid),
		.first_tap_o (first_tap),
		.last_tap_o  (last_tap),
		.res_addr_o  (seq_res_addr),
		.run_done_o  (run_done)
	);

	// one sample per cycle, shared by both kernels
	data_ram #(.DEPTH(conv_pkg::FM_WORDS), .WIDTH(conv_pkg::DATA_WIDTH)) i_fm_ram (
		.clk     (clk),
		.we_i    (fm_we),
		.waddr_i (wr_addr),
		.wdata_i (wr_data),
		.raddr_i (fm_raddr),
		.rdata_o (fm_rdata)
	);

	for (genvar k = 0; k < conv_pkg::PARA_KERNEL; k++) begin : g_kernel
		logic res_we;
		conv_pkg::res_addr_t res_waddr;
		conv_pkg::acc_t res_wdata;

		data_ram #(.DEPTH(conv_pkg::WEIGHT_WORDS), .WIDTH(conv_pkg::DATA_WIDTH)) i_w_ram (
			.clk     (clk),
			.we_i    (w_we[k]),
			.waddr_i (wr_addr[$bits(conv_pkg::w_addr_t)-1:0]),
			.wdata_i (wr_data),
			.raddr_i (w_raddr),
			.rdata_o (w_rdata[k])
		);

		mac_unit i_mac_unit (
			.clk         (clk),
			.rst         (rst),
			.tap_valid_i (tap_valid),
			.first_tap_i (first_tap),
			.last_tap_i  (last_tap),
			.res_addr_i  (seq_res_addr),
			.sample_i    (fm_rdata),
			.weight_i    (w_rdata[k]),
			.res_we_o    (res_we),
			.res_waddr_o (res_waddr),
			.res_wdata_o (res_wdata)
		);

		data_ram #(.DEPTH(conv_pkg::RESULT_WORDS), .WIDTH(conv_pkg::ACC_WIDTH)) i_res_ram (
			.clk     (clk),
			.we_i    (res_we),
			.waddr_i (res_waddr),
			.wdata_i (res_wdata),
			.raddr_i (res_raddr),
			.rdata_o (res_rdata[k])
		);
	end

endmodule

//--- include/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

logic [31:0] lfsr_state = 32'h5d59;
int error_count = 0;
int test_errors = 0; // errors of the test in progress
int tests_run = 0;
int tests_failed = 0;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit
function automatic logic [7:0] random_byte();
	logic [7:0] b;
	for (int i = 0; i < 8; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		b[i] = lfsr_state[0];
	end
	return b;
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (exp !== act) begin
		$display("** Error %s: expected %h, actual %h", name, exp, act);
		error_count++;
		test_errors++;
	end
endtask

task automatic report_test(input string name);
	tests_run++;
	if (test_errors == 0) begin
		$display("test %s passed", name);
	end else begin
		tests_failed++;
		$display("test %s failed with %0d errors", name, test_errors);
	end
	test_errors = 0;
endtask

`endif

//--- bench/tb_conv_layer.sv
module tb_conv_layer;

	timeunit 1ns;
	timeprecision 1ps;

	`include "tb_util.svh"

	// two runs at size 8 depth 1, two at size 5 depth 2
	localparam int RUN_CYCLES = 2 * (36 * 9 + 3) + 2 * (9 * 18 + 3);
	localparam int APB_CYCLES = 4 * 800; // about 800 transfers of at most 4 cycles
	localparam int TIMEOUT = 2 * (RUN_CYCLES + APB_CYCLES) + 10;

	logic clk = 1'b0;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	int cycle_count = 0;
	int wait_cycles = 0; // pready low cycles of the last transfer
	logic signed [7:0] fm_model [conv_pkg::FM_WORDS];
	logic signed [7:0] w_model [conv_pkg::PARA_KERNEL][conv_pkg::WEIGHT_WORDS];

	conv_layer_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic apb_transfer(input logic write, input logic [11:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		wait_cycles = 0;
		#1;
		while (!pready) begin // ram read wait state
			wait_cycles++;
			@(negedge clk);
			#1;
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk); // transfer completed on the rising edge before
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
		apb_transfer(1'b0, addr, 32'h0, data, err);
	endtask

	task automatic wait_done();
		logic [31:0] ctrl;
		logic err;
		ctrl = 32'h0;
		while (ctrl != 32'h2) begin // done set, busy clear
			apb_read(conv_pkg::REG_CTRL, ctrl, err);
		end
	endtask

	function automatic int conv_model(input int k, input int oy, input int ox, input int depth);
		int sum;
		sum = 0;
		for (int s = 0; s < depth; s++) begin
			for (int ky = 0; ky < conv_pkg::KERNEL_SIZE; ky++) begin
				for (int kx = 0; kx < conv_pkg::KERNEL_SIZE; kx++) begin
					sum += int'(fm_model[s * 64 + (oy + ky) * 8 + ox + kx])
						* int'(w_model[k][s * 9 + ky * 3 + kx]);
				end
			end
		end
		return sum;
	endfunction

	task automatic check_results(input string name, input int size, input int depth);
		logic [31:0] rd;
		logic err;
		for (int k = 0; k < conv_pkg::PARA_KERNEL; k++) begin
			for (int oy = 0; oy < size - 2; oy++) begin
				for (int ox = 0; ox < size - 2; ox++) begin
					apb_read(12'(conv_pkg::RESULT_BASE + k * conv_pkg::RESULT_STRIDE
						+ oy * conv_pkg::OUT_SIZE_MAX + ox), rd, err);
					check_value(name, 32'(conv_model(k, oy, ox, depth)), rd);
					check_value(name, 32'h0, 32'(err));
					check_value(name, 32'd1, 32'(wait_cycles)); // one ram read wait state
				end
			end
		end
	endtask

	initial begin
		logic [31:0] rd;
		logic err;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rst = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		apb_read(conv_pkg::REG_CTRL, rd, err);
		check_value("reset_cfg", 32'h0, rd);
		check_value("reset_cfg", 32'd0, 32'(wait_cycles)); // registers answer at once
		apb_write(conv_pkg::REG_CFG, 32'h9, err);
		apb_read(conv_pkg::REG_CFG, rd, err);
		check_value("reset_cfg", 32'h8, rd); // size clamped to 8
		apb_write(conv_pkg::REG_CFG, 32'h15, err);
		apb_read(conv_pkg::REG_CFG, rd, err);
		check_value("reset_cfg", 32'h15, rd);
		report_test("reset_cfg");

		for (int a = 0; a < conv_pkg::FM_WORDS; a++) begin
			fm_model[a] = random_byte();
			apb_write(12'(conv_pkg::FM_BASE + a), {24'h0, fm_model[a]}, err);
		end
		for (int k = 0; k < conv_pkg::PARA_KERNEL; k++) begin
			for (int a = 0; a < conv_pkg::WEIGHT_WORDS; a++) begin
				w_model[k][a] = random_byte();
				apb_write(12'(conv_pkg::WEIGHT_BASE + k * conv_pkg::WEIGHT_STRIDE + a),
					{24'h0, w_model[k][a]}, err);
			end
		end
		for (int a = 0; a < conv_pkg::FM_WORDS; a++) begin
			apb_read(12'(conv_pkg::FM_BASE + a), rd, err);
			check_value("load_readback", 32'(int'(fm_model[a])), rd);
			check_value("load_readback", 32'd1, 32'(wait_cycles));
		end
		for (int k = 0; k < conv_pkg::PARA_KERNEL; k++) begin
			for (int a = 0; a < conv_pkg::WEIGHT_WORDS; a++) begin
				apb_read(12'(conv_pkg::WEIGHT_BASE + k * conv_pkg::WEIGHT_STRIDE + a), rd, err);
				check_value("load_readback", 32'(int'(w_model[k][a])), rd);
				check_value("load_readback", 32'd1, 32'(wait_cycles));
			end
		end
		report_test("load_readback");

		apb_write(conv_pkg::REG_CFG, 32'h08, err); // size 8, one slice
		apb_write(conv_pkg::REG_CTRL, 32'h1, err);
		wait_done();
		check_results("run_size8_depth1", 8, 1);
		report_test("run_size8_depth1");

		apb_write(conv_pkg::REG_CFG, 32'h15, err); // size 5, two slices
		apb_write(conv_pkg::REG_CTRL, 32'h1, err);
		wait_done();
		check_results("run_size5_depth2", 5, 2);
		report_test("run_size5_depth2");

		apb_write(conv_pkg::REG_CTRL, 32'h1, err);
		apb_write(12'(conv_pkg::FM_BASE + 9), {24'h0, ~fm_model[9]}, err);
		check_value("busy_errors", 32'h1, 32'(err));
		apb_write(conv_pkg::REG_CTRL, 32'h1, err); // second start, ignored
		apb_read(12'h300, rd, err);
		check_value("busy_errors", 32'h1, 32'(err));
		check_value("busy_errors", 32'h0, rd);
		check_value("busy_errors", 32'd0, 32'(wait_cycles)); // error ends without a wait
		wait_done();
		repeat (3) begin
			apb_read(conv_pkg::REG_CTRL, rd, err);
			check_value("busy_errors", 32'h2, rd);
		end
		check_results("busy_errors", 5, 2);
		report_test("busy_errors");

		apb_write(conv_pkg::REG_CFG, 32'h08, err);
		apb_write(conv_pkg::REG_CTRL, 32'h1, err);
		apb_read(conv_pkg::REG_CTRL, rd, err);
		check_value("restart", 32'h1, rd); // busy, done cleared
		wait_done();
		check_results("restart", 8, 1);
		report_test("restart");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+include
logic/conv_pkg.sv
logic/data_ram.sv
logic/apb_regs.sv
logic/window_sequencer.sv
logic/mac_unit.sv
logic/conv_layer_top.sv
bench/tb_conv_layer.sv
